//--- all.f
rtl/mm_pkg.sv
rtl/mm_periph_if.sv
rtl/mm_reg_slave.sv
rtl/mm_tiler.sv
rtl/mm_ctrl.sv
rtl/mm_tile_sequencer.sv
rtl/mm_ctrl_top.sv
tests/tb_clk_gen.sv
tests/tb_mm_ctrl_top.sv

//--- rtl/mm_ctrl.sv
// Controller FSM for one job context
// Start latch, busy, clear and flush generation
// Holds the register slave and the tiler

module mm_ctrl
  import mm_pkg::*;
#(
  parameter int unsigned NumCores    = 8,
  parameter int unsigned Height      = 4,
  parameter int unsigned Width       = 8,
  parameter int unsigned NumPipeRegs = 3
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     w_loaded_i,
  input  logic                     z_ready_i,
  input  logic                     r_ready_i,
  input  tile_cnt_t                tiles_done_i,
  mm_periph_if.slave               periph,
  output logic                     busy_o,
  output logic                     clear_o,
  output logic                     flush_o,
  output logic                     cfg_complete_o,
  output logic                     first_load_o,
  output logic                     finished_o,
  output logic [NumCores-1:0][1:0] evt_o,
  output tile_cnt_t                tiles_m_o,
  output tile_cnt_t                tiles_n_o,
  output tile_cnt_t                tiles_total_o,
  output dim_t                     k_o,
  output red_mode_e                red_mode_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        slave_start;
  logic        slave_clear;
  logic        start_latch_q;
  logic        tiler_valid;
  logic        tiler_setback;
  logic        done;
  dim_t        cfg_m;
  dim_t        cfg_n;
  dim_t        cfg_k;
  red_mode_e   cfg_red_mode;

  mm_reg_slave #(
    .NumCores (NumCores)
  ) mm_reg_slave_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .busy_i       (busy_o),
    .done_i       (done),
    .tiles_done_i (tiles_done_i),
    .periph       (periph),
    .start_o      (slave_start),
    .clear_o      (slave_clear),
    .m_o          (cfg_m),
    .n_o          (cfg_n),
    .k_o          (cfg_k),
    .red_mode_o   (cfg_red_mode),
    .evt_o        (evt_o)
  );

  // Trigger write doubles as the tiler latch strobe
  mm_tiler #(
    .Height      (Height),
    .Width       (Width),
    .NumPipeRegs (NumPipeRegs)
  ) mm_tiler_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_o),
    .setback_i     (tiler_setback),
    .start_cfg_i   (slave_start),
    .m_i           (cfg_m),
    .n_i           (cfg_n),
    .k_i           (cfg_k),
    .red_mode_i    (cfg_red_mode),
    .valid_o       (tiler_valid),
    .tiles_m_o     (tiles_m_o),
    .tiles_n_o     (tiles_n_o),
    .tiles_total_o (tiles_total_o),
    .k_o           (k_o),
    .red_mode_o    (red_mode_o)
  );

  // State register, soft clear forces IDLE
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= LATCH_RST;
    end else if (slave_clear) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Pending trigger until the job is taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_latch_q <= 1'b0;
    end else if (clear_o || tiler_setback) begin
      start_latch_q <= 1'b0;
    end else if (slave_start) begin
      start_latch_q <= 1'b1;
    end
  end

  // Next-state logic
  always_comb begin
    state_d = state_q;
    case (state_q)
      LATCH_RST: state_d = IDLE;
      IDLE: begin
        if (start_latch_q && tiler_valid) begin
          state_d = STARTING;
        end
      end
      STARTING: begin
        if (w_loaded_i) begin
          state_d = COMPUTING;
        end
      end
      COMPUTING: begin
        // Reduction jobs also wait for the R sink
        if (z_ready_i && ((red_mode_o == RED_NONE) || r_ready_i)) begin
          state_d = FINISHED;
        end
      end
      FINISHED:  state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  assign tiler_setback  = (state_q == IDLE) && (state_d == STARTING);
  assign done           = (state_q == FINISHED);
  assign busy_o         = (state_q == STARTING) || (state_q == COMPUTING);
  assign flush_o        = done;
  assign finished_o     = done;
  assign first_load_o   = (state_q == STARTING);
  assign cfg_complete_o = tiler_valid;
  // One clear cycle out of reset as well
  assign clear_o        = slave_clear || (state_q == LATCH_RST);

endmodule

//--- rtl/mm_ctrl_top.sv
// Top level of the matrix-multiply controller
// Plain peripheral ports bundled onto the internal bus
// Controller and tile sequencer wiring

module mm_ctrl_top
  import mm_pkg::*;
#(
  parameter int unsigned NumCores    = 8,
  parameter int unsigned Height      = 4,
  parameter int unsigned Width       = 8,
  parameter int unsigned NumPipeRegs = 3
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     periph_req_i,
  input  logic                     periph_we_i,
  input  addr_t                    periph_addr_i,
  input  word_t                    periph_wdata_i,
  output word_t                    periph_rdata_o,
  output logic                     periph_rvalid_o,
  output logic                     busy_o,
  output logic                     flush_o,
  output logic                     cfg_complete_o,
  output logic [NumCores-1:0][1:0] evt_o
);

  logic      clear;
  logic      first_load;
  logic      finished;
  logic      w_loaded;
  logic      z_ready;
  logic      r_ready;
  tile_cnt_t tiles_n;
  tile_cnt_t tiles_total;
  tile_cnt_t tiles_done;
  dim_t      job_k;
  red_mode_e job_red_mode;

  mm_periph_if periph_bus ();

  // Host side of the bus
  assign periph_bus.req   = periph_req_i;
  assign periph_bus.we    = periph_we_i;
  assign periph_bus.addr  = periph_addr_i;
  assign periph_bus.wdata = periph_wdata_i;
  assign periph_rdata_o   = periph_bus.rdata;
  assign periph_rvalid_o  = periph_bus.rvalid;

  mm_ctrl #(
    .NumCores    (NumCores),
    .Height      (Height),
    .Width       (Width),
    .NumPipeRegs (NumPipeRegs)
  ) mm_ctrl_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .w_loaded_i     (w_loaded),
    .z_ready_i      (z_ready),
    .r_ready_i      (r_ready),
    .tiles_done_i   (tiles_done),
    .periph         (periph_bus),
    .busy_o         (busy_o),
    .clear_o        (clear),
    .flush_o        (flush_o),
    .cfg_complete_o (cfg_complete_o),
    .first_load_o   (first_load),
    .finished_o     (finished),
    .evt_o          (evt_o),
    .tiles_m_o      (),
    .tiles_n_o      (tiles_n),
    .tiles_total_o  (tiles_total),
    .k_o            (job_k),
    .red_mode_o     (job_red_mode)
  );

  // Sequencer works from the total and the column count
  mm_tile_sequencer mm_tile_sequencer_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear),
    .first_load_i  (first_load),
    .finished_i    (finished),
    .tiles_n_i     (tiles_n),
    .tiles_total_i (tiles_total),
    .k_i           (job_k),
    .red_mode_i    (job_red_mode),
    .w_loaded_o    (w_loaded),
    .z_ready_o     (z_ready),
    .r_ready_o     (r_ready),
    .tiles_done_o  (tiles_done)
  );

endmodule

//--- rtl/mm_periph_if.sv
// Peripheral request bundle between host side and register file
// Master drives the request, slave answers one cycle later

interface mm_periph_if
  import mm_pkg::*;
();

  // Request side
  logic  req;
  logic  we;
  addr_t addr;
  word_t wdata;

  // Response side
  word_t rdata;
  logic  rvalid;

  modport master (
    output req, we, addr, wdata,
    input  rdata, rvalid
  );

  modport slave (
    input  req, we, addr, wdata,
    output rdata, rvalid
  );

endinterface

//--- rtl/mm_pkg.sv
// Shared types and constants for the matrix-multiply controller
// Word, address, dimension and tile-count types
// Reduction mode and controller state encodings
// Peripheral register map

package mm_pkg;

  // Word index on the peripheral port
  typedef logic [2:0] addr_t;

  // Peripheral data word
  typedef logic [31:0] word_t;

  // One matrix dimension (M, N or K)
  typedef logic [15:0] dim_t;

  // Number of tiles in a job
  typedef logic [15:0] tile_cnt_t;

  // Reduction applied after the tile loop
  typedef enum logic [1:0] {
    RED_NONE = 2'd0,
    RED_SUM  = 2'd1,
    RED_MAX  = 2'd2
  } red_mode_e;

  // Controller sequence
  typedef enum logic [2:0] {
    LATCH_RST,
    IDLE,
    STARTING,
    COMPUTING,
    FINISHED
  } ctrl_state_e;

  // Register map, one word per index
  localparam addr_t REG_TRIGGER    = 3'd0;
  localparam addr_t REG_STATUS     = 3'd1;
  localparam addr_t REG_SOFT_CLEAR = 3'd2;
  localparam addr_t REG_M          = 3'd3;
  localparam addr_t REG_N          = 3'd4;
  localparam addr_t REG_K          = 3'd5;
  localparam addr_t REG_CONF       = 3'd6;
  localparam addr_t REG_TILES_DONE = 3'd7;

  // Reduction mode field inside REG_CONF
  localparam int unsigned ConfRedLsb = 1;
  localparam int unsigned ConfRedMsb = 2;

  // Busy flag position in REG_STATUS
  localparam int unsigned StatusBusyBit = 0;

endpackage

//--- rtl/mm_reg_slave.sv
// Register file on the peripheral port
// Job registers, trigger and soft-clear strobes, status readback
// Tile-count capture and per-core completion events

module mm_reg_slave
  import mm_pkg::*;
#(
  parameter int unsigned NumCores = 8
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     busy_i,
  input  logic                     done_i,
  input  tile_cnt_t                tiles_done_i,
  mm_periph_if.slave               periph,
  output logic                     start_o,
  output logic                     clear_o,
  output dim_t                     m_o,
  output dim_t                     n_o,
  output dim_t                     k_o,
  output red_mode_e                red_mode_o,
  output logic [NumCores-1:0][1:0] evt_o
);

  logic      wr_en;
  logic      rd_en;
  dim_t      m_q;
  dim_t      n_q;
  dim_t      k_q;
  word_t     conf_q;
  tile_cnt_t tiles_done_q;
  word_t     rdata_d;
  word_t     rdata_q;
  logic      rvalid_q;

  // Port never stalls, so a request is a single-cycle strobe
  assign wr_en = periph.req & periph.we;
  assign rd_en = periph.req & ~periph.we;

  // Command strobes act in the cycle of the write
  assign start_o = wr_en && (periph.addr == REG_TRIGGER);
  assign clear_o = wr_en && (periph.addr == REG_SOFT_CLEAR);

  // Job registers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      m_q    <= '0;
      n_q    <= '0;
      k_q    <= '0;
      conf_q <= '0;
    end else if (wr_en) begin
      case (periph.addr)
        REG_M:    m_q    <= dim_t'(periph.wdata);
        REG_N:    n_q    <= dim_t'(periph.wdata);
        REG_K:    k_q    <= dim_t'(periph.wdata);
        REG_CONF: conf_q <= periph.wdata;
        // Trigger, clear and read-only slots hold nothing
        default:  ;
      endcase
    end
  end

  // Tile count of the last finished job
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tiles_done_q <= '0;
    end else if (done_i) begin
      tiles_done_q <= tiles_done_i;
    end
  end

  // Read mux
  always_comb begin
    rdata_d = '0;
    case (periph.addr)
      REG_STATUS:     rdata_d[StatusBusyBit] = busy_i;
      REG_M:          rdata_d = word_t'(m_q);
      REG_N:          rdata_d = word_t'(n_q);
      REG_K:          rdata_d = word_t'(k_q);
      REG_CONF:       rdata_d = conf_q;
      REG_TILES_DONE: rdata_d = word_t'(tiles_done_q);
      default:        rdata_d = '0;
    endcase
  end

  // Read response one cycle after the request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  assign periph.rdata  = rdata_q;
  assign periph.rvalid = rvalid_q;

  assign m_o        = m_q;
  assign n_o        = n_q;
  assign k_o        = k_q;
  assign red_mode_o = red_mode_e'(conf_q[ConfRedMsb:ConfRedLsb]);

  // Completion event on bit 0 of each core line, bit 1 unused
  always_comb begin
    for (int c = 0; c < NumCores; c++) begin
      evt_o[c] = {1'b0, done_i};
    end
  end

endmodule

//--- rtl/mm_tile_sequencer.sv
// Stand-in for scheduler and streamers
// Weight-load count, per-tile K-cycle loop, optional reduction drain
// Loaded and sink-ready flags plus running tile count

module mm_tile_sequencer
  import mm_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  logic      first_load_i,
  input  logic      finished_i,
  input  tile_cnt_t tiles_n_i,
  input  tile_cnt_t tiles_total_i,
  input  dim_t      k_i,
  input  red_mode_e red_mode_i,
  output logic      w_loaded_o,
  output logic      z_ready_o,
  output logic      r_ready_o,
  output tile_cnt_t tiles_done_o
);

  dim_t      load_cnt_q;
  dim_t      cyc_cnt_q;
  tile_cnt_t tile_cnt_q;
  tile_cnt_t drain_cnt_q;
  logic      comp_q;
  logic      drain_q;
  logic      z_ready_q;
  logic      r_ready_q;
  logic      tile_end;
  logic      last_tile;
  logic      z_set;
  logic      drain_end;

  // Counters compare against count + 1 so that zero sizes still finish
  assign w_loaded_o = first_load_i && (32'(load_cnt_q) + 32'd1 >= 32'(k_i));
  assign tile_end   = comp_q && (32'(cyc_cnt_q) + 32'd1 >= 32'(k_i));
  assign last_tile  = tile_end && (32'(tile_cnt_q) + 32'd1 >= 32'(tiles_total_i));
  // Empty job goes straight to the Z sink
  assign z_set      = last_tile || (w_loaded_o && (tiles_total_i == '0));
  assign drain_end  = drain_q && (32'(drain_cnt_q) + 32'd1 >= 32'(tiles_n_i));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      load_cnt_q  <= '0;
      cyc_cnt_q   <= '0;
      tile_cnt_q  <= '0;
      drain_cnt_q <= '0;
      comp_q      <= 1'b0;
      drain_q     <= 1'b0;
      z_ready_q   <= 1'b0;
      r_ready_q   <= 1'b0;
    end else if (clear_i) begin
      load_cnt_q  <= '0;
      cyc_cnt_q   <= '0;
      tile_cnt_q  <= '0;
      drain_cnt_q <= '0;
      comp_q      <= 1'b0;
      drain_q     <= 1'b0;
      z_ready_q   <= 1'b0;
      r_ready_q   <= 1'b0;
    end else begin
      // Weight load, K cycles in STARTING
      if (first_load_i && !w_loaded_o) begin
        load_cnt_q <= load_cnt_q + 1'b1;
      end else begin
        load_cnt_q <= '0;
      end

      // Tile loop
      if (w_loaded_o) begin
        comp_q <= (tiles_total_i != '0);
      end else if (last_tile) begin
        comp_q <= 1'b0;
      end
      if (tile_end || !comp_q) begin
        cyc_cnt_q <= '0;
      end else begin
        cyc_cnt_q <= cyc_cnt_q + 1'b1;
      end
      if (first_load_i) begin
        tile_cnt_q <= '0;
      end else if (tile_end) begin
        tile_cnt_q <= tile_cnt_q + 1'b1;
      end

      // Reduction drain, tiles_n cycles after Z
      if (z_set && (red_mode_i != RED_NONE)) begin
        drain_q <= 1'b1;
      end else if (drain_end) begin
        drain_q <= 1'b0;
      end
      if (drain_q && !drain_end) begin
        drain_cnt_q <= drain_cnt_q + 1'b1;
      end else begin
        drain_cnt_q <= '0;
      end

      // Sink flags held until the controller finishes
      if (finished_i) begin
        z_ready_q <= 1'b0;
        r_ready_q <= 1'b0;
      end else begin
        if (z_set) begin
          z_ready_q <= 1'b1;
        end
        if (drain_end) begin
          r_ready_q <= 1'b1;
        end
      end
    end
  end

  assign z_ready_o    = z_ready_q;
  assign r_ready_o    = r_ready_q;
  assign tiles_done_o = tile_cnt_q;

endmodule

//--- rtl/mm_tiler.sv
// Job latch and tile-count computation
// Ceiling division of M by the tile row size and N by the array width
// Valid flag held from start until setback or clear

module mm_tiler
  import mm_pkg::*;
#(
  parameter int unsigned Height      = 4,
  parameter int unsigned Width       = 8,
  parameter int unsigned NumPipeRegs = 3
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  logic      setback_i,
  input  logic      start_cfg_i,
  input  dim_t      m_i,
  input  dim_t      n_i,
  input  dim_t      k_i,
  input  red_mode_e red_mode_i,
  output logic      valid_o,
  output tile_cnt_t tiles_m_o,
  output tile_cnt_t tiles_n_o,
  output tile_cnt_t tiles_total_o,
  output dim_t      k_o,
  output red_mode_e red_mode_o
);

  // Rows covered by one pass through the pipelined array
  localparam int unsigned TileRow = (NumPipeRegs + 1) * Height;

  tile_cnt_t tiles_m_d;
  tile_cnt_t tiles_n_d;
  tile_cnt_t tiles_m_q;
  tile_cnt_t tiles_n_q;
  tile_cnt_t tiles_total_q;
  dim_t      k_q;
  red_mode_e red_mode_q;
  logic      valid_q;

  // Ceiling divisions by constants
  assign tiles_m_d = tile_cnt_t'((32'(m_i) + TileRow - 1) / TileRow);
  assign tiles_n_d = tile_cnt_t'((32'(n_i) + Width - 1) / Width);

  // Job snapshot taken with the trigger write
  always_ff @(posedge clk_i) begin
    if (start_cfg_i) begin
      tiles_m_q     <= tiles_m_d;
      tiles_n_q     <= tiles_n_d;
      tiles_total_q <= tile_cnt_t'(32'(tiles_m_d) * 32'(tiles_n_d));
      k_q           <= k_i;
      red_mode_q    <= red_mode_i;
    end
  end

  // Valid until the controller consumes the job
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (clear_i || setback_i) begin
      valid_q <= 1'b0;
    end else if (start_cfg_i) begin
      valid_q <= 1'b1;
    end
  end

  assign valid_o       = valid_q;
  assign tiles_m_o     = tiles_m_q;
  assign tiles_n_o     = tiles_n_q;
  assign tiles_total_o = tiles_total_q;
  assign k_o           = k_q;
  assign red_mode_o    = red_mode_q;

endmodule

//--- tests/tb_clk_gen.sv
// Clock and reset source for the testbench
// 4 ns clock, active-low reset held for a fixed number of cycles

module tb_clk_gen #(
  parameter int unsigned ResetCycles = 4
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  // Half period of 2 ns
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Release just after a rising edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

//--- tests/tb_mm_ctrl_top.sv
// Testbench for the matrix-multiply controller top level
// Register access tasks, reference tile and latency functions
// Typed compare tasks, event monitor and cycle-limit watchdog

module tb_mm_ctrl_top
  import mm_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumCores    = 8;
  localparam int unsigned Height      = 4;
  localparam int unsigned Width       = 8;
  localparam int unsigned NumPipeRegs = 3;
  localparam int unsigned TileRow     = (NumPipeRegs + 1) * Height;
  localparam int unsigned NumJobs     = 10;
  // Job that gets cut short by a soft clear
  localparam int unsigned ClearJob    = 4;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     periph_req_i;
  logic                     periph_we_i;
  addr_t                    periph_addr_i;
  word_t                    periph_wdata_i;
  word_t                    periph_rdata_o;
  logic                     periph_rvalid_o;
  logic                     busy_o;
  logic                     flush_o;
  logic                     cfg_complete_o;
  logic [NumCores-1:0][1:0] evt_o;

  dim_t        job_m [NumJobs];
  dim_t        job_n [NumJobs];
  dim_t        job_k [NumJobs];
  red_mode_e   job_mode [NumJobs];
  int unsigned cycle_cnt   = 0;
  int unsigned cycle_limit = 32'hFFFF_FFFF;
  int unsigned busy_cycles = 0;
  int unsigned evt_count   = 0;
  int unsigned evt_before  = 0;

  tb_clk_gen #(.ResetCycles(4)) tb_clk_gen_inst (.clk_o(clk_i), .rst_no(rst_ni));

  mm_ctrl_top #(
    .NumCores    (NumCores),
    .Height      (Height),
    .Width       (Width),
    .NumPipeRegs (NumPipeRegs)
  ) mm_ctrl_top_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .periph_req_i    (periph_req_i),
    .periph_we_i     (periph_we_i),
    .periph_addr_i   (periph_addr_i),
    .periph_wdata_i  (periph_wdata_i),
    .periph_rdata_o  (periph_rdata_o),
    .periph_rvalid_o (periph_rvalid_o),
    .busy_o          (busy_o),
    .flush_o         (flush_o),
    .cfg_complete_o  (cfg_complete_o),
    .evt_o           (evt_o)
  );

  // Ceiling of N over the array width
  function automatic tile_cnt_t expected_tiles_n(input dim_t n);
    return tile_cnt_t'((32'(n) + Width - 1) / Width);
  endfunction

  // Tiles of a job: ceil(M / row size) times ceil(N / width)
  function automatic tile_cnt_t expected_tiles(input dim_t m, input dim_t n);
    int unsigned tm;
    tm = (32'(m) + TileRow - 1) / TileRow;
    return tile_cnt_t'(tm * 32'(expected_tiles_n(n)));
  endfunction

  // Weight load, K per tile, plus drain when reducing
  function automatic int unsigned min_busy_cycles(input dim_t m, input dim_t n,
                                                  input dim_t k, input red_mode_e mode);
    int unsigned cyc;
    cyc = 32'(k) + 32'(expected_tiles(m, n)) * 32'(k);
    if (mode != RED_NONE) begin
      cyc = cyc + 32'(expected_tiles_n(n));
    end
    return cyc;
  endfunction

  // Watchdog share of one job
  function automatic int unsigned job_budget(input dim_t m, input dim_t n, input dim_t k);
    return (32'(k) + 1) * (32'(expected_tiles(m, n)) + 1) + 32'(expected_tiles_n(n));
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR time=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp));
    end
  endtask

  task automatic check_tiles(input string name, input tile_cnt_t got, input tile_cnt_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR time=%0t %s got=%0d expected=%0d", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR time=%0t %s got=%b expected=%b", $time, name, got, exp));
    end
  endtask

  // One-cycle write strobe
  task automatic write_reg(input addr_t addr, input word_t data);
    periph_req_i   = 1'b1;
    periph_we_i    = 1'b1;
    periph_addr_i  = addr;
    periph_wdata_i = data;
    @(posedge clk_i);
    #1;
    periph_req_i = 1'b0;
    periph_we_i  = 1'b0;
    // Writes get no read response
    check_bit("periph_rvalid_o", periph_rvalid_o, 1'b0);
  endtask

  // Response expected on the cycle after the request
  task automatic read_reg(input addr_t addr, output word_t data);
    periph_req_i  = 1'b1;
    periph_we_i   = 1'b0;
    periph_addr_i = addr;
    @(posedge clk_i);
    #1;
    periph_req_i = 1'b0;
    check_bit("periph_rvalid_o", periph_rvalid_o, 1'b1);
    data = periph_rdata_o;
  endtask

  // Program a job and trigger it
  task automatic start_job(input int unsigned idx);
    write_reg(REG_M, word_t'(job_m[idx]));
    write_reg(REG_N, word_t'(job_n[idx]));
    write_reg(REG_K, word_t'(job_k[idx]));
    write_reg(REG_CONF, word_t'(job_mode[idx]) << ConfRedLsb);
    busy_cycles = 0;
    evt_before  = evt_count;
    write_reg(REG_TRIGGER, 32'h1);
    // Tiler valid for one cycle, then the FSM takes the job
    check_bit("cfg_complete_o", cfg_complete_o, 1'b1);
    check_bit("busy_o", busy_o, 1'b0);
    @(posedge clk_i);
    #1;
    check_bit("busy_o", busy_o, 1'b1);
    check_bit("cfg_complete_o", cfg_complete_o, 1'b0);
  endtask

  // Wait for the completion event, then check the results
  task automatic finish_job(input int unsigned idx);
    word_t rd;
    while (evt_count == evt_before) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("flush_o", flush_o, 1'b0);
    if (busy_cycles < min_busy_cycles(job_m[idx], job_n[idx], job_k[idx], job_mode[idx])) begin
      abort_run($sformatf("Job %0d was busy for %0d cycles, less than the minimum %0d",
                          idx, busy_cycles,
                          min_busy_cycles(job_m[idx], job_n[idx], job_k[idx], job_mode[idx])));
    end
    read_reg(REG_TILES_DONE, rd);
    check_tiles("REG_TILES_DONE", tile_cnt_t'(rd), expected_tiles(job_m[idx], job_n[idx]));
    read_reg(REG_STATUS, rd);
    check_word("REG_STATUS", rd, '0);
    if (evt_count != evt_before + 1) begin
      abort_run($sformatf("Job %0d produced %0d completion events instead of one",
                          idx, evt_count - evt_before));
    end
  endtask

  task automatic run_job(input int unsigned idx);
    start_job(idx);
    finish_job(idx);
  endtask

  // Fixed jobs at 0 and ClearJob, the rest random
  task automatic build_jobs();
    for (int unsigned i = 0; i < NumJobs; i++) begin
      job_m[i]    = dim_t'(1 + ($urandom % 64));
      job_n[i]    = dim_t'(1 + ($urandom % 32));
      job_k[i]    = dim_t'(1 + ($urandom % 8));
      job_mode[i] = (i < 4) ? RED_SUM : red_mode_e'($urandom % 3);
    end
    job_m[0]           = 16'd20;
    job_n[0]           = 16'd12;
    job_k[0]           = 16'd3;
    job_mode[0]        = RED_NONE;
    job_m[ClearJob]    = 16'd40;
    job_n[ClearJob]    = 16'd20;
    job_k[ClearJob]    = 16'd6;
    job_mode[ClearJob] = RED_NONE;
    job_mode[5]        = RED_NONE;
  endtask

  // Watchdog
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      abort_run($sformatf("Timeout after %0d cycles without finishing the tests", cycle_cnt));
    end
  end

  // Event monitor, sampled mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (busy_o) begin
        busy_cycles++;
      end
      // Every core line pulses bit 0 together with the flush
      for (int c = 0; c < NumCores; c++) begin
        check_bit($sformatf("evt_o[%0d][0]", c), evt_o[c][0], flush_o);
        check_bit($sformatf("evt_o[%0d][1]", c), evt_o[c][1], 1'b0);
      end
      if (flush_o) begin
        check_bit("busy_o", busy_o, 1'b0);
        evt_count++;
      end
    end
  end

  initial begin : main_seq
    int unsigned seed_ret;
    word_t       rd;
    periph_req_i   = 1'b0;
    periph_we_i    = 1'b0;
    periph_addr_i  = '0;
    periph_wdata_i = '0;
    seed_ret = $urandom(32'h7104_ffd6);
    build_jobs();
    cycle_limit = 200;
    for (int unsigned i = 0; i < NumJobs; i++) begin
      cycle_limit = cycle_limit + job_budget(job_m[i], job_n[i], job_k[i]);
    end

    wait (rst_ni === 1'b1);
    @(posedge clk_i);
    #1;

    // Quiet after reset
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("flush_o", flush_o, 1'b0);
    check_bit("cfg_complete_o", cfg_complete_o, 1'b0);
    for (int c = 0; c < NumCores; c++) begin
      check_bit($sformatf("evt_o[%0d][0]", c), evt_o[c][0], 1'b0);
    end
    read_reg(REG_STATUS, rd);
    check_word("REG_STATUS", rd, '0);

    // Register readback
    write_reg(REG_M, 32'h0000_1234);
    write_reg(REG_N, 32'h0000_0abc);
    write_reg(REG_K, 32'h0000_0042);
    write_reg(REG_CONF, 32'h0000_0004);
    read_reg(REG_M, rd);
    check_word("REG_M", rd, 32'h0000_1234);
    read_reg(REG_N, rd);
    check_word("REG_N", rd, 32'h0000_0abc);
    read_reg(REG_K, rd);
    check_word("REG_K", rd, 32'h0000_0042);
    read_reg(REG_CONF, rd);
    check_word("REG_CONF", rd, 32'h0000_0004);

    // Plain job, then reduction jobs
    for (int unsigned i = 0; i < ClearJob; i++) begin
      run_job(i);
    end

    // Soft clear in the middle of the tile loop
    start_job(ClearJob);
    repeat (job_k[ClearJob] + 4) @(posedge clk_i);
    #1;
    check_bit("busy_o", busy_o, 1'b1);
    write_reg(REG_SOFT_CLEAR, 32'h1);
    check_bit("busy_o", busy_o, 1'b0);
    repeat (job_budget(job_m[ClearJob], job_n[ClearJob], job_k[ClearJob])) @(posedge clk_i);
    #1;
    check_bit("busy_o", busy_o, 1'b0);
    if (evt_count != evt_before) begin
      abort_run("A completion event appeared after the soft clear");
    end

    // Job after the clear, then back-to-back random jobs
    for (int unsigned i = ClearJob + 1; i < NumJobs; i++) begin
      run_job(i);
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
